// File: Bender.yml
package:
  name: mxt

sources:
  - rtl/mxt_cfg_pkg.sv
  - rtl/mxt_ctrl_pkg.sv
  - rtl/mxt_flow_fsm.sv
  - rtl/tile_counter.sv
  - rtl/tile_store.sv
  - rtl/tile_transpose.sv
  - rtl/mxt_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/mxt_checker.sv
      - test/mxt_tb.sv

// File: mxt.f
rtl/mxt_cfg_pkg.sv
rtl/mxt_ctrl_pkg.sv
rtl/mxt_flow_fsm.sv
rtl/tile_counter.sv
rtl/tile_store.sv
rtl/tile_transpose.sv
rtl/mxt_top.sv
test/tb_clock.sv
test/mxt_checker.sv
test/mxt_tb.sv

// File: rtl/mxt_cfg_pkg.sv
`default_nettype none

package mxt_cfg_pkg;

  // Bits per matrix element
  localparam int DATA_WIDTH = 8;

  // Side of one square compute tile
  localparam int TILE_DIM = 2;

  // Tile row/column index width, up to 16 tiles per side
  localparam int POS_WIDTH = 4;

  // One compute tile, indexed elem[row][col]
  typedef struct packed {
    logic [TILE_DIM-1:0][TILE_DIM-1:0][DATA_WIDTH-1:0] elem;
  } chunk_t;

  // Tile position inside the matrix
  typedef struct packed {
    logic [POS_WIDTH-1:0] row;
    logic [POS_WIDTH-1:0] col;
  } tile_pos_t;

endpackage

`default_nettype wire

// File: rtl/mxt_ctrl_pkg.sv
`default_nettype none

package mxt_ctrl_pkg;

  // Sequencer phases
  // S_FILL accepts a matrix, S_DRAIN reads it back out transposed
  typedef enum logic [0:0] {
    S_FILL  = 1'b0,
    S_DRAIN = 1'b1
  } flow_state_t;

endpackage

`default_nettype wire

// File: rtl/mxt_flow_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module mxt_flow_fsm (
  input  logic clk,
  input  logic rst,

  // Write side
  input  logic in_valid,
  input  logic wr_last,
  output logic in_ready,

  // Read side
  input  logic rd_last,
  input  logic out_valid,
  input  logic out_ready,
  output logic rd_step
);

  mxt_ctrl_pkg::flow_state_t state;
  mxt_ctrl_pkg::flow_state_t state_next;

  logic wr_done;
  logic rd_done;
  logic out_free;

  // Input is taken only while filling
  assign in_ready = (state == mxt_ctrl_pkg::S_FILL);

  // Output register empty, or emptied this cycle
  assign out_free = !out_valid || out_ready;

  assign rd_step = (state == mxt_ctrl_pkg::S_DRAIN) && out_free;

  // Last chunk of the matrix written / read
  assign wr_done = in_valid && in_ready && wr_last;
  assign rd_done = rd_step && rd_last;

  always_comb begin
    state_next = state;
    case (state)
      mxt_ctrl_pkg::S_FILL: begin
        if (wr_done) begin
          state_next = mxt_ctrl_pkg::S_DRAIN;
        end
      end
      mxt_ctrl_pkg::S_DRAIN: begin
        // Refill may start while the last chunk still waits in the output stage
        if (rd_done) begin
          state_next = mxt_ctrl_pkg::S_FILL;
        end
      end
      default: begin
        state_next = mxt_ctrl_pkg::S_FILL;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mxt_ctrl_pkg::S_FILL;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

// File: rtl/mxt_top.sv
`timescale 1ns/10ps
`default_nettype none

module mxt_top #(
  parameter int TILE_ROWS = 2,
  parameter int TILE_COLS = 3
) (
  input  logic                clk,
  input  logic                rst,

  // Input stream, row-major tiles
  input  mxt_cfg_pkg::chunk_t in_chunk,
  input  logic                in_valid,
  output logic                in_ready,

  // Output stream, transposed matrix in row-major tiles
  output mxt_cfg_pkg::chunk_t out_chunk,
  output logic                out_valid,
  input  logic                out_ready
);

  logic                   wr_step;
  logic                   wr_last;
  mxt_cfg_pkg::tile_pos_t wr_pos;

  logic                   rd_step;
  logic                   rd_last;
  mxt_cfg_pkg::tile_pos_t rd_pos;

  mxt_cfg_pkg::chunk_t    rd_chunk;

  // Accepted input transfer
  assign wr_step = in_valid && in_ready;

  mxt_flow_fsm i_fsm (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .wr_last   (wr_last),
    .in_ready  (in_ready),
    .rd_last   (rd_last),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .rd_step   (rd_step)
  );

  // Walks the input grid
  tile_counter #(
    .OUTER (TILE_ROWS),
    .INNER (TILE_COLS)
  ) i_wr_cnt (
    .clk  (clk),
    .rst  (rst),
    .step (wr_step),
    .pos  (wr_pos),
    .last (wr_last)
  );

  // Walks the transposed grid
  tile_counter #(
    .OUTER (TILE_COLS),
    .INNER (TILE_ROWS)
  ) i_rd_cnt (
    .clk  (clk),
    .rst  (rst),
    .step (rd_step),
    .pos  (rd_pos),
    .last (rd_last)
  );

  tile_store #(
    .TILE_ROWS (TILE_ROWS),
    .TILE_COLS (TILE_COLS)
  ) i_store (
    .clk      (clk),
    .wr_en    (wr_step),
    .wr_pos   (wr_pos),
    .wr_chunk (in_chunk),
    .rd_pos   (rd_pos),
    .rd_chunk (rd_chunk)
  );

  tile_transpose i_xpose (
    .clk       (clk),
    .rst       (rst),
    .load      (rd_step),
    .in_chunk  (rd_chunk),
    .out_ready (out_ready),
    .out_chunk (out_chunk),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

// File: rtl/tile_counter.sv
`timescale 1ns/10ps
`default_nettype none

module tile_counter #(
  parameter int OUTER = 2,
  parameter int INNER = 3
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   step,
  output mxt_cfg_pkg::tile_pos_t pos,
  output logic                   last
);

  localparam int PW = mxt_cfg_pkg::POS_WIDTH;

  // Final index on each axis
  localparam logic [PW-1:0] ROW_MAX = PW'(OUTER - 1);
  localparam logic [PW-1:0] COL_MAX = PW'(INNER - 1);

  logic row_end;
  logic col_end;

  initial begin
    if (OUTER < 1 || OUTER > 2 ** PW) begin
      $fatal(1, "tile_counter: OUTER out of range for POS_WIDTH");
    end
    if (INNER < 1 || INNER > 2 ** PW) begin
      $fatal(1, "tile_counter: INNER out of range for POS_WIDTH");
    end
  end

  assign row_end = (pos.row == ROW_MAX);
  assign col_end = (pos.col == COL_MAX);
  assign last    = row_end && col_end;

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= '0;
    end else if (step) begin
      if (last) begin
        // End of matrix, back to the first tile
        pos <= '0;
      end else if (col_end) begin
        pos.row <= pos.row + 1'b1;
        pos.col <= '0;
      end else begin
        pos.col <= pos.col + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/tile_store.sv
`timescale 1ns/10ps
`default_nettype none

module tile_store #(
  parameter int TILE_ROWS = 2,
  parameter int TILE_COLS = 3
) (
  input  logic                   clk,

  // Row-major write of incoming tiles
  input  logic                   wr_en,
  input  mxt_cfg_pkg::tile_pos_t wr_pos,
  input  mxt_cfg_pkg::chunk_t    wr_chunk,

  // Position in the transposed matrix
  input  mxt_cfg_pkg::tile_pos_t rd_pos,
  output mxt_cfg_pkg::chunk_t    rd_chunk
);

  localparam int DEPTH      = TILE_ROWS * TILE_COLS;
  localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // One whole matrix of tiles
  mxt_cfg_pkg::chunk_t mem [DEPTH];

  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] rd_addr;

  always_comb begin
    wr_addr = ADDR_WIDTH'(wr_pos.row * TILE_COLS + wr_pos.col);
    // Output tile (r, c) is stored tile (c, r)
    rd_addr = ADDR_WIDTH'(rd_pos.col * TILE_COLS + rd_pos.row);
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_chunk;
    end
  end

  assign rd_chunk = mem[rd_addr];

endmodule

`default_nettype wire

// File: rtl/tile_transpose.sv
`timescale 1ns/10ps
`default_nettype none

module tile_transpose (
  input  logic                clk,
  input  logic                rst,
  input  logic                load,
  input  mxt_cfg_pkg::chunk_t in_chunk,
  input  logic                out_ready,
  output mxt_cfg_pkg::chunk_t out_chunk,
  output logic                out_valid
);

  localparam int DIM = mxt_cfg_pkg::TILE_DIM;

  mxt_cfg_pkg::chunk_t xposed;

  // Element swap within the tile
  always_comb begin
    for (int r = 0; r < DIM; r++) begin
      for (int c = 0; c < DIM; c++) begin
        xposed.elem[r][c] = in_chunk.elem[c][r];
      end
    end
  end

  // Held output data
  always_ff @(posedge clk) begin
    if (load) begin
      out_chunk <= xposed;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      // Transfer with nothing new behind it
      out_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: test/mxt_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mxt_checker (
  input logic                clk,
  input logic                rst,
  input logic                in_ready,
  input logic                rd_step,
  input logic                out_valid,
  input logic                out_ready,
  input mxt_cfg_pkg::chunk_t out_chunk
);

  // Output held while the sink stalls
  stall_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_chunk))
    else $error("output stream changed while stalled");

  // Fill and drain never overlap
  no_overlap: assert property (@(posedge clk) disable iff (rst)
    !(in_ready && rd_step))
    else $error("in_ready and rd_step high in the same cycle");

  reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high right after reset");

endmodule

bind mxt_top mxt_checker i_checker (
  .clk       (clk),
  .rst       (rst),
  .in_ready  (in_ready),
  .rd_step   (rd_step),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_chunk (out_chunk)
);

`default_nettype wire

// File: test/mxt_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mxt_tb;

  localparam int TR             = 2;
  localparam int TC             = 3;
  localparam int D              = mxt_cfg_pkg::TILE_DIM;
  localparam int CHUNKS         = TR * TC;
  localparam int N_MAT          = 6;
  localparam int TOTAL          = N_MAT * CHUNKS;
  localparam int TIMEOUT_CYCLES = N_MAT * CHUNKS * 8 + 50;

  // One matrix per row, probabilities in percent
  typedef struct packed {
    logic [7:0] base;
    logic [7:0] gap_pct;
    logic [7:0] stall_pct;
  } mat_case_t;

  localparam mat_case_t CASES [N_MAT] = '{
    '{8'h00, 8'd0,  8'd0},
    '{8'h31, 8'd0,  8'd0},
    '{8'h5a, 8'd40, 8'd0},
    '{8'h87, 8'd60, 8'd0},
    '{8'hc4, 8'd60, 8'd60},
    '{8'hf0, 8'd70, 8'd50}
  };

  logic                clk;
  logic                rst;
  mxt_cfg_pkg::chunk_t in_chunk;
  logic                in_valid;
  logic                in_ready;
  mxt_cfg_pkg::chunk_t out_chunk;
  logic                out_valid;
  logic                out_ready;

  mxt_cfg_pkg::chunk_t expected [TOTAL];
  int                  seed = 32'h5c9;
  int                  in_cnt = 0;
  int                  out_cnt = 0;
  int                  cycle_cnt = 0;
  logic                in_fire = 1'b0;
  logic                exp_ready;

  tb_clock #(.PERIOD(10), .RESET_CYCLES(2)) i_clock (.clk(clk), .rst(rst));

  mxt_top #(
    .TILE_ROWS (TR),
    .TILE_COLS (TC)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_chunk  (in_chunk),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_chunk (out_chunk),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on error");
  endtask

  // Input element (i, j) of the full matrix is base + 16*i + j
  function automatic mxt_cfg_pkg::chunk_t input_chunk(input int idx);
    mxt_cfg_pkg::chunk_t c;
    int m;
    int k;
    m = idx / CHUNKS;
    k = idx % CHUNKS;
    for (int a = 0; a < D; a++) begin
      for (int b = 0; b < D; b++) begin
        c.elem[a][b] = 8'(CASES[m].base + 16 * ((k / TC) * D + a) + (k % TC) * D + b);
      end
    end
    return c;
  endfunction

  // Output grid is TC by TR tiles; element (r, c) of it is input (c, r)
  function automatic mxt_cfg_pkg::chunk_t expected_chunk(input int idx);
    mxt_cfg_pkg::chunk_t c;
    int m;
    int k;
    m = idx / CHUNKS;
    k = idx % CHUNKS;
    for (int a = 0; a < D; a++) begin
      for (int b = 0; b < D; b++) begin
        c.elem[a][b] = 8'(CASES[m].base + 16 * ((k % TR) * D + b) + (k / TR) * D + a);
      end
    end
    return c;
  endfunction

  function automatic logic roll(input int pct);
    logic [31:0] r;
    r = $random(seed);
    return (r % 100) < pct;
  endfunction

  // Stimulus, both streams from one process
  initial begin
    in_valid  = 1'b0;
    out_ready = 1'b0;
    in_chunk  = '0;
    for (int i = 0; i < TOTAL; i++) begin
      expected[i] = expected_chunk(i);
    end
    @(negedge rst);
    forever begin
      @(posedge clk);
      // A pending chunk stays valid until taken
      if (!(in_valid && !in_fire)) begin
        if (in_cnt < TOTAL) begin
          if (roll(CASES[in_cnt / CHUNKS].gap_pct)) begin
            in_valid <= 1'b0;
          end else begin
            in_valid <= 1'b1;
            in_chunk <= input_chunk(in_cnt);
          end
        end else begin
          in_valid <= 1'b0;
        end
      end
      if (out_cnt < TOTAL) begin
        out_ready <= !roll(CASES[out_cnt / CHUNKS].stall_pct);
      end else begin
        out_ready <= 1'b1;
      end
    end
  end

  // Mid-cycle sampling of handshakes and scoreboard
  always @(negedge clk) begin
    if (!rst) begin
      in_fire   = in_valid && in_ready;
      // Ready once every stored matrix has been loaded for output
      exp_ready = (out_cnt + int'(out_valid)) >= (in_cnt - in_cnt % CHUNKS);
      assert (in_ready == exp_ready)
        else abort_run($sformatf("Error: in_ready = %h, expected %h", in_ready, exp_ready));
      assert (out_cnt + int'(out_valid) <= in_cnt - in_cnt % CHUNKS)
        else abort_run("Output chunk presented with no stored matrix chunk left to read");
      if (out_valid && out_ready) begin
        assert (out_chunk == expected[out_cnt])
          else abort_run($sformatf("Error: out_chunk[%0d] = %h, expected %h",
                                   out_cnt, out_chunk, expected[out_cnt]));
        out_cnt++;
      end
      if (in_fire) begin
        in_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: not all output chunks arrived within the cycle limit");
    end
  end

  initial begin
    @(negedge rst);
    wait (out_cnt == TOTAL);
    repeat (4) @(negedge clk);
    assert (!out_valid && in_ready) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run($sformatf("Error: out_valid = %h in_ready = %h, expected 0 and 1",
                          out_valid, in_ready));
    end
  end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire
